/* verilog/lift_pkg.sv */
`default_nettype none

package lift_pkg;

    ////////////////////
    // Building size
    ////////////////////

    localparam int NUM_FLOORS = 7;

    // Top floor has no up button, ground floor has no down button
    localparam int NUM_HALL = NUM_FLOORS - 1;

    // One bit per floor
    typedef logic [NUM_FLOORS-1:0] floor_vec_t;

    // Up calls: bit i is floor i. Down calls: bit i is floor i+1
    typedef logic [NUM_HALL-1:0] hall_vec_t;

    ////////////////////
    // Calls and demand
    ////////////////////

    typedef struct packed {
        floor_vec_t car;
        hall_vec_t  hall_up;
        hall_vec_t  hall_down;
    } lift_calls_t;

    // Summary of pending work as seen from the sensed floor
    typedef struct packed {
        logic above;
        logic below;
        logic car_here;
        logic up_here;
        logic down_here;
        logic sensor_ok;
    } lift_demand_t;

    ////////////////////
    // Car state
    ////////////////////

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_UP         = 3'd1,
        ST_DOWN       = 3'd2,
        ST_DOOR_OPEN  = 3'd3,
        ST_DOOR_WAIT  = 3'd4,
        ST_DOOR_CLOSE = 3'd5
    } lift_state_e;

endpackage

`default_nettype wire

/* verilog/call_registry.sv */
`timescale 1ns/1ps
`default_nettype none

module call_registry (
    input  logic                  clk,
    input  logic                  poweron,
    input  lift_pkg::lift_calls_t pulses,
    input  lift_pkg::lift_calls_t served,
    output lift_pkg::lift_calls_t pending
);
    import lift_pkg::*;

    lift_calls_t pending_nxt;

    ////////////////////
    // Set and clear
    ////////////////////

    // A new press beats a clear in the same cycle
    always_comb begin
        pending_nxt = pending;

        // Car panel, one button per floor
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (pulses.car[f]) begin
                pending_nxt.car[f] = 1'b1;
            end else if (served.car[f]) begin
                pending_nxt.car[f] = 1'b0;
            end
        end

        // Hall buttons
        for (int h = 0; h < NUM_HALL; h++) begin
            if (pulses.hall_up[h]) begin
                pending_nxt.hall_up[h] = 1'b1;
            end else if (served.hall_up[h]) begin
                pending_nxt.hall_up[h] = 1'b0;
            end

            if (pulses.hall_down[h]) begin
                pending_nxt.hall_down[h] = 1'b1;
            end else if (served.hall_down[h]) begin
                pending_nxt.hall_down[h] = 1'b0;
            end
        end
    end

    ////////////////////
    // Call flags
    ////////////////////

    always_ff @(posedge clk or posedge poweron) begin
        if (poweron) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/direction_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module direction_planner (
    input  lift_pkg::floor_vec_t   floor_sensor,
    input  lift_pkg::lift_calls_t  pending,
    output lift_pkg::lift_demand_t demand
);
    import lift_pkg::*;

    floor_vec_t up_at;
    floor_vec_t down_at;
    floor_vec_t any_at;
    floor_vec_t above_mask;
    floor_vec_t below_mask;
    logic       seen_one;
    logic       seen_more;

    ////////////////////
    // Sensor check
    ////////////////////

    always_comb begin
        seen_one  = 1'b0;
        seen_more = 1'b0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (floor_sensor[f]) begin
                if (seen_one) begin
                    seen_more = 1'b1;
                end
                seen_one = 1'b1;
            end
        end
    end

    ////////////////////
    // Calls per floor
    ////////////////////

    always_comb begin
        up_at   = '0;
        down_at = '0;
        for (int h = 0; h < NUM_HALL; h++) begin
            up_at[h] = pending.hall_up[h];
            // down button h sits one floor higher
            down_at[h+1] = pending.hall_down[h];
        end
    end

    assign any_at = pending.car | up_at | down_at;

    // Floors strictly above and strictly below the sensed one
    always_comb begin
        logic lower_hit;
        logic upper_hit;

        lower_hit = 1'b0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            above_mask[f] = lower_hit;
            lower_hit     = lower_hit | floor_sensor[f];
        end

        upper_hit = 1'b0;
        for (int f = NUM_FLOORS - 1; f >= 0; f--) begin
            below_mask[f] = upper_hit;
            upper_hit     = upper_hit | floor_sensor[f];
        end
    end

    ////////////////////
    // Demand flags
    ////////////////////

    always_comb begin
        demand.above     = |(any_at & above_mask);
        demand.below     = |(any_at & below_mask);
        demand.car_here  = |(pending.car & floor_sensor);
        demand.up_here   = |(up_at & floor_sensor);
        demand.down_here = |(down_at & floor_sensor);
        demand.sensor_ok = seen_one & ~seen_more;
    end

endmodule

`default_nettype wire

/* verilog/car_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module car_sequencer #(
    parameter int DOOR_CYCLES = 30
) (
    input  logic                   clk,
    input  logic                   poweron,
    input  lift_pkg::floor_vec_t   floor_sensor,
    input  lift_pkg::lift_demand_t demand,
    output lift_pkg::lift_calls_t  served,
    output logic                   motor_up,
    output logic                   motor_down,
    output logic                   door_open,
    output logic                   fault
);
    import lift_pkg::*;

    localparam int CNT_W = (DOOR_CYCLES > 1) ? $clog2(DOOR_CYCLES) : 1;
    localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(DOOR_CYCLES - 1);

    lift_state_e      state;
    lift_state_e      next_state;
    logic [CNT_W-1:0] door_cnt;
    logic             door_q;
    logic             stop_idle;
    logic             stop_up;
    logic             stop_down;
    logic             clr_up;
    logic             clr_down;
    logic             door_held;
    logic             door_busy;

    ////////////////////
    // Stop rules
    ////////////////////

    assign stop_idle = demand.car_here | demand.up_here | demand.down_here;

    // Opposite hall call only taken at the end of the run
    assign stop_up   = demand.car_here | demand.up_here |
                       (~demand.above & demand.down_here);
    assign stop_down = demand.car_here | demand.down_here |
                       (~demand.below & demand.up_here);

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        next_state = state;
        clr_up     = 1'b0;
        clr_down   = 1'b0;

        case (state)
            ST_IDLE: begin
                if (!demand.sensor_ok) begin
                    next_state = ST_IDLE;
                end else if (stop_idle) begin
                    next_state = ST_DOOR_OPEN;
                    clr_up     = 1'b1;
                    clr_down   = 1'b1;
                end else if (demand.above) begin
                    next_state = ST_UP;
                end else if (demand.below) begin
                    next_state = ST_DOWN;
                end
            end

            ST_UP: begin
                if (!demand.sensor_ok) begin
                    next_state = ST_IDLE;
                end else if (stop_up) begin
                    next_state = ST_DOOR_OPEN;
                    clr_up     = 1'b1;
                    clr_down   = ~demand.above;
                end else if (!demand.above) begin
                    next_state = ST_IDLE;
                end
            end

            ST_DOWN: begin
                if (!demand.sensor_ok) begin
                    next_state = ST_IDLE;
                end else if (stop_down) begin
                    next_state = ST_DOOR_OPEN;
                    clr_down   = 1'b1;
                    clr_up     = ~demand.below;
                end else if (!demand.below) begin
                    next_state = ST_IDLE;
                end
            end

            ST_DOOR_OPEN: begin
                next_state = ST_DOOR_WAIT;
            end

            ST_DOOR_WAIT: begin
                if (door_cnt == '0) begin
                    next_state = ST_DOOR_CLOSE;
                end
            end

            // Always decide again from idle
            ST_DOOR_CLOSE: begin
                next_state = ST_IDLE;
            end

            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    ////////////////////
    // Clear mask
    ////////////////////

    // Only in the cycle the stop is taken
    always_comb begin
        served = '0;
        if (next_state == ST_DOOR_OPEN) begin
            served.car = floor_sensor;
            if (clr_up) begin
                served.hall_up = floor_sensor[NUM_HALL-1:0];
            end
            if (clr_down) begin
                served.hall_down = floor_sensor[NUM_FLOORS-1:1];
            end
        end
    end

    ////////////////////
    // State and door timer
    ////////////////////

    always_ff @(posedge clk or posedge poweron) begin
        if (poweron) begin
            state    <= ST_IDLE;
            door_cnt <= '0;
            door_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_DOOR_OPEN) begin
                door_cnt <= WAIT_LOAD;
            end else if (state == ST_DOOR_WAIT && door_cnt != '0) begin
                door_cnt <= door_cnt - 1'b1;
            end
            // Door follows the open states one cycle late
            door_q <= door_held;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign door_held = (state == ST_DOOR_OPEN) || (state == ST_DOOR_WAIT);
    assign door_busy = door_held || (state == ST_DOOR_CLOSE);

    // Lost position stops the car at once
    assign motor_up   = (state == ST_UP) && demand.sensor_ok;
    assign motor_down = (state == ST_DOWN) && demand.sensor_ok;
    assign fault      = ~demand.sensor_ok && ~door_busy;
    assign door_open  = door_q;

endmodule

`default_nettype wire

/* verilog/lift_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lift_top #(
    parameter int DOOR_CYCLES = 30
) (
    input  logic                  clk,
    input  logic                  poweron,
    input  lift_pkg::floor_vec_t  floor_sensor,
    input  lift_pkg::lift_calls_t call_pulses,
    output lift_pkg::lift_calls_t pending,
    output logic                  motor_up,
    output logic                  motor_down,
    output logic                  door_open,
    output logic                  fault
);
    import lift_pkg::*;

    lift_demand_t demand;
    lift_calls_t  served;

    ////////////////////
    // Call latches
    ////////////////////

    call_registry u_call_registry (
        .clk     (clk),
        .poweron (poweron),
        .pulses  (call_pulses),
        .served  (served),
        .pending (pending)
    );

    ////////////////////
    // Where the work is
    ////////////////////

    direction_planner u_direction_planner (
        .floor_sensor (floor_sensor),
        .pending      (pending),
        .demand       (demand)
    );

    ////////////////////
    // Car control
    ////////////////////

    car_sequencer #(
        .DOOR_CYCLES (DOOR_CYCLES)
    ) u_car_sequencer (
        .clk          (clk),
        .poweron      (poweron),
        .floor_sensor (floor_sensor),
        .demand       (demand),
        .served       (served),
        .motor_up     (motor_up),
        .motor_down   (motor_down),
        .door_open    (door_open),
        .fault        (fault)
    );

endmodule

`default_nettype wire

/* verif/lift_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module lift_chk (
    input logic clk,
    input logic poweron,
    input logic motor_up,
    input logic motor_down,
    input logic door_open,
    input logic fault
);

    ////////////////////
    // Motor exclusivity
    ////////////////////

    motors_apart: assert property (@(posedge clk) disable iff (poweron)
        !(motor_up && motor_down))
        else $error("motor_up and motor_down on together");

    // Car never moves with the door open
    door_stopped: assert property (@(posedge clk) disable iff (poweron)
        door_open |-> !(motor_up || motor_down))
        else $error("motor running while door_open is high");

    fault_stopped: assert property (@(posedge clk) disable iff (poweron)
        fault |-> !(motor_up || motor_down))
        else $error("motor running while fault is high");

endmodule

`default_nettype wire

/* include/lift_tb_table.svh */
`ifndef LIFT_TB_TABLE_SVH
`define LIFT_TB_TABLE_SVH

localparam int NUM_ROWS  = 4;
localparam int MAX_STOPS = 3;

// Stops are listed first to last, unused slots hold 0
typedef struct packed {
    logic [2:0]                start_floor;
    logic                      drop_sensor;
    lift_calls_t               pulses;
    logic [1:0]                num_stops;
    logic [MAX_STOPS-1:0][2:0] stops;
    lift_calls_t               exp_pending;
    logic [1:0]                exp_moves;
    logic [3:0]                exp_latency;
} scenario_t;

scenario_t scenarios [NUM_ROWS];
string     scenario_names [NUM_ROWS];

task automatic add_row(input int idx, input string name, input int start, input logic drop,
                       input floor_vec_t car, input hall_vec_t up, input hall_vec_t down,
                       input int nstops, input int s0, input int s1, input int s2,
                       input lift_calls_t after, input logic [1:0] moves, input int latency);
    scenario_t row;

    row                   = '0;
    row.start_floor       = 3'(start);
    row.drop_sensor       = drop;
    row.pulses.car        = car;
    row.pulses.hall_up    = up;
    row.pulses.hall_down  = down;
    row.num_stops         = 2'(nstops);
    row.stops[0]          = 3'(s0);
    row.stops[1]          = 3'(s1);
    row.stops[2]          = 3'(s2);
    row.exp_pending       = after;
    row.exp_moves         = moves;
    row.exp_latency       = 4'(latency);
    scenarios[idx]        = row;
    scenario_names[idx]   = name;
endtask

// Columns: row, name, start floor, sensor drop, car, hall up, hall down,
// stop count, stops, pending after, motors seen {down, up}, door latency (0 = unchecked)
task automatic load_scenarios();
    add_row(0, "hall_call_here", 4, 1'b0, 7'b0000000, 6'b010000, 6'b000000,
            1, 4, 0, 0, '0, 2'b00, 3);
    add_row(1, "up_sweep_then_down", 0, 1'b0, 7'b0100000, 6'b000100, 6'b000100,
            3, 2, 5, 3, '0, 2'b11, 0);
    add_row(2, "down_from_top", 6, 1'b0, 7'b0000010, 6'b000000, 6'b000000,
            1, 1, 0, 0, '0, 2'b10, 0);
    add_row(3, "sensor_loss", 3, 1'b1, 7'b0000010, 6'b010000, 6'b000000,
            2, 4, 1, 0, '0, 2'b11, 0);
endtask

`endif

/* verif/lift_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lift_tb;
    import lift_pkg::*;

    localparam int DOOR_CYCLES   = 4;
    localparam int STEP_CYCLES   = 3;
    localparam int SETTLE_CYCLES = 6;

    logic        clk;
    logic        poweron;
    floor_vec_t  floor_sensor;
    lift_calls_t call_pulses;
    lift_calls_t pending;
    logic        motor_up;
    logic        motor_down;
    logic        door_open;
    logic        fault;

    `include "lift_tb_table.svh"

    localparam int TIMEOUT_CYCLES =
        NUM_ROWS * (NUM_FLOORS * 4 + MAX_STOPS * (DOOR_CYCLES + 5)) + 50;

    int         car_floor;
    int         move_cnt;
    logic       sensor_on;
    int         cyc = 0;
    int         seen_stops [$];
    int         open_len;
    int         first_open_cyc;
    logic       door_was_open;
    logic [1:0] moves_seen;
    string      cur_name;

    lift_top #(
        .DOOR_CYCLES (DOOR_CYCLES)
    ) u_lift_top (
        .clk          (clk),
        .poweron      (poweron),
        .floor_sensor (floor_sensor),
        .call_pulses  (call_pulses),
        .pending      (pending),
        .motor_up     (motor_up),
        .motor_down   (motor_down),
        .door_open    (door_open),
        .fault        (fault)
    );

    bind lift_top lift_chk u_lift_chk (
        .clk        (clk),
        .poweron    (poweron),
        .motor_up   (motor_up),
        .motor_down (motor_down),
        .door_open  (door_open),
        .fault      (fault)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input int expected, input int actual);
        abort_run($sformatf("error %s %s: expected 0x%0h, actual 0x%0h",
                            cur_name, what, expected, actual));
    endtask

    function automatic void drive_sensor();
        floor_sensor = '0;
        if (sensor_on) begin
            floor_sensor[car_floor] = 1'b1;
        end
    endfunction

    ////////////////////
    // Shaft model
    ////////////////////

    // Sensor moves straight to the next floor once the step is done
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (motor_up || motor_down) begin
            move_cnt++;
            if (move_cnt == STEP_CYCLES) begin
                move_cnt  = 0;
                car_floor = motor_up ? car_floor + 1 : car_floor - 1;
                assert (car_floor >= 0 && car_floor < NUM_FLOORS)
                    else abort_run("Car was driven past the end of the shaft");
            end
        end else begin
            move_cnt = 0;
        end
        drive_sensor();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run("Run reached its cycle limit without finishing");
        end
    end

    ////////////////////
    // Output monitor
    ////////////////////

    always @(negedge clk) begin
        if (!poweron) begin
            assert (!(motor_up && motor_down))
                else abort_run("Both motors were on together");
            assert (!(door_open && (motor_up || motor_down)))
                else abort_run("A motor ran with the door open");
            assert (!(fault && (motor_up || motor_down)))
                else abort_run("A motor ran while the fault flag was up");
            if (motor_up) begin
                moves_seen[0] = 1'b1;
            end
            if (motor_down) begin
                moves_seen[1] = 1'b1;
            end
            if (door_open) begin
                if (!door_was_open) begin
                    seen_stops.push_back(car_floor);
                    if (first_open_cyc < 0) begin
                        first_open_cyc = cyc;
                    end
                    open_len = 0;
                end
                open_len++;
            end else if (door_was_open) begin
                assert (open_len == DOOR_CYCLES + 1)
                    else report_mismatch("door open cycles", DOOR_CYCLES + 1, open_len);
            end
            door_was_open = door_open;
        end
    end

    ////////////////////
    // Scenario loop
    ////////////////////

    initial begin
        int        gap;
        int        pulse_cyc;
        scenario_t sc;

        void'($urandom(2));
        poweron        = 1'b1;
        call_pulses    = '0;
        car_floor      = 0;
        move_cnt       = 0;
        sensor_on      = 1'b1;
        moves_seen     = '0;
        door_was_open  = 1'b0;
        open_len       = 0;
        first_open_cyc = -1;
        pulse_cyc      = 0;
        cur_name       = "reset";
        drive_sensor();
        load_scenarios();

        next_cycle();
        next_cycle();
        poweron = 1'b0;
        next_cycle();
        @(negedge clk);
        assert (pending == '0) else report_mismatch("pending", 0, pending);
        assert ({motor_up, motor_down, door_open, fault} == 4'b0000)
            else report_mismatch("outputs", 0, {motor_up, motor_down, door_open, fault});

        for (int r = 0; r < NUM_ROWS; r++) begin
            sc       = scenarios[r];
            cur_name = scenario_names[r];
            gap      = $urandom % 4 + 1;
            repeat (gap) next_cycle();

            // Car is parked, so it can be placed at the start floor
            car_floor      = sc.start_floor;
            sensor_on      = !sc.drop_sensor;
            drive_sensor();
            seen_stops.delete();
            moves_seen     = '0;
            first_open_cyc = -1;

            next_cycle();
            pulse_cyc   = cyc;
            call_pulses = sc.pulses;
            next_cycle();
            call_pulses = '0;

            if (sc.drop_sensor) begin
                next_cycle();
                @(negedge clk);
                assert (fault) else report_mismatch("fault without sensor", 1, fault);
                assert (pending == sc.pulses)
                    else report_mismatch("pending without sensor", sc.pulses, pending);
                next_cycle();
                sensor_on = 1'b1;
                drive_sensor();
                @(negedge clk);
                assert (!fault) else report_mismatch("fault after restore", 0, fault);
            end

            while (seen_stops.size() < sc.num_stops || door_was_open) begin
                next_cycle();
            end
            repeat (SETTLE_CYCLES) next_cycle();
            @(negedge clk);

            assert (seen_stops.size() == sc.num_stops)
                else report_mismatch("stop count", sc.num_stops, seen_stops.size());
            for (int s = 0; s < seen_stops.size(); s++) begin
                assert (seen_stops[s] == sc.stops[s])
                    else report_mismatch($sformatf("stop %0d floor", s), sc.stops[s],
                                         seen_stops[s]);
            end
            assert (pending == sc.exp_pending)
                else report_mismatch("pending", sc.exp_pending, pending);
            assert (moves_seen == sc.exp_moves)
                else report_mismatch("motors seen", sc.exp_moves, moves_seen);
            if (sc.exp_latency != 0) begin
                assert (first_open_cyc - pulse_cyc == sc.exp_latency)
                    else report_mismatch("door latency", sc.exp_latency,
                                         first_open_cyc - pulse_cyc);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/lift_pkg.sv
verilog/call_registry.sv
verilog/direction_planner.sv
verilog/car_sequencer.sv
verilog/lift_top.sv
verif/lift_chk.sv
verif/lift_tb.sv
